// ==== hw/execute_pkg.sv ====
package execute_pkg;

    // lsb positions of the instruction word fields
    localparam int cond_lsb   = 28;
    localparam int opcode_lsb = 21;
    localparam int rd_lsb     = 17;
    localparam int rn_lsb     = 13;
    localparam int rs_lsb     = 9;
    localparam int rm_lsb     = 5;
    localparam int imm5_lsb   = 0;

    localparam logic [3:0]  cond_never = 4'b1111;
    localparam logic [6:0]  opcode_nop = 7'b0100000;
    localparam logic [31:0] nop_word   = {4'b0000, opcode_nop, 21'b0};

    // opcode classes
    localparam logic [1:0] form_imm    = 2'b00;  // bits 5..4 of a normal op
    localparam logic [1:0] form_r      = 2'b01;
    localparam logic [1:0] form_rs     = 2'b11;
    localparam logic [1:0] class_mem   = 2'b11;  // bits 6..5
    localparam int         alu_a_bit   = 3;      // normal op reads rn
    localparam int         mem_ldr_bit = 4;      // clear for STR
    localparam int         mem_reg_bit = 3;      // register offset

    typedef enum logic [3:0] {
        alu_mov = 4'b0000,
        alu_mvn = 4'b0001,
        alu_add = 4'b1000,
        alu_sub = 4'b1001,
        alu_and = 4'b1010,
        alu_orr = 4'b1011,
        alu_eor = 4'b1100
    } alu_op_t;

    typedef enum logic [1:0] {sel_reg = 2'b00, sel_alu = 2'b01} fwd_sel_t;

    typedef enum logic {kind_write = 1'b0, kind_addr = 1'b1} result_kind_t;

    // normal alu instruction, nop (form 10) excluded
    function automatic logic is_normal(input logic [6:0] op);
        return !op[6] && op[5:4] != 2'b10;
    endfunction

    function automatic logic is_mem(input logic [6:0] op);
        return op[6:5] == class_mem;
    endfunction

endpackage

// ==== hw/instr_credit_queue.sv ====
module instr_credit_queue #(
    parameter int queue_depth = 4
) (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        in_valid,
    input  logic [31:0] in_instr,
    input  logic        in_squash,
    input  logic        pop,
    output logic        out_empty,
    output logic [31:0] out_instr,
    output logic        out_squash,
    output logic        credit
);
    localparam int ptr_w = (queue_depth > 1) ? $clog2(queue_depth) : 1;

    logic [31:0]      instr_mem  [queue_depth];
    logic             squash_mem [queue_depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w:0]   count;
    logic             do_pop;

    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] p);
        return (p == ptr_w'(queue_depth - 1)) ? '0 : p + 1'b1;  // wrap for any depth
    endfunction

    assign out_empty  = count == '0;
    assign do_pop     = pop && !out_empty;
    assign out_instr  = instr_mem[rd_ptr];
    assign out_squash = squash_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (in_valid) begin  // issuer only sends with a credit, so never full here
            instr_mem[wr_ptr]  <= in_instr;
            squash_mem[wr_ptr] <= in_squash;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            credit <= 1'b0;
        end else begin
            if (in_valid) wr_ptr <= next_ptr(wr_ptr);
            if (do_pop) rd_ptr <= next_ptr(rd_ptr);
            count  <= count + in_valid - do_pop;
            credit <= do_pop;  // slot goes back to the issuer
        end
    end

endmodule

// ==== hw/execute_pipeline_unit.sv ====
module execute_pipeline_unit
    import execute_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  logic [31:0] instr_in,
    input  logic        squash_in,   // instruction in a taken branch shadow
    input  logic        sel_stall,
    output logic [3:0]  cond,
    output logic [6:0]  opcode,
    output logic [3:0]  rn,
    output logic [3:0]  rs,
    output logic [3:0]  rm,
    output logic [3:0]  rd,
    output logic [4:0]  imm5,
    output logic [31:0] instr_output
);
    logic [31:0] instr_e;
    logic        kill;

    // squashed or never-executed words become a nop
    assign kill = squash_in || instr_in[cond_lsb +: 4] == cond_never;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            instr_e <= nop_word;
        end else if (!sel_stall) begin
            instr_e <= kill ? nop_word : instr_in;
        end
    end

    // field split of the held word
    assign cond   = instr_e[cond_lsb +: 4];
    assign opcode = instr_e[opcode_lsb +: 7];
    assign rd     = instr_e[rd_lsb +: 4];
    assign rn     = instr_e[rn_lsb +: 4];
    assign rs     = instr_e[rs_lsb +: 4];
    assign rm     = instr_e[rm_lsb +: 4];
    assign imm5   = instr_e[imm5_lsb +: 5];

    assign instr_output = instr_e;

endmodule

// ==== hw/execute_unit.sv ====
module execute_unit
    import execute_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  logic [31:0] instr_in,
    input  logic        squash_in,
    input  logic        sel_stall,
    output logic [6:0]  opcode,
    output logic [3:0]  rn,
    output logic [3:0]  rs,
    output logic [3:0]  rm,
    output logic [3:0]  rd,
    output logic [4:0]  imm5,
    input  logic [6:0]  opcode_x,      // instruction one stage ahead
    input  logic [3:0]  rd_x,
    output fwd_sel_t    sel_a_in,
    output fwd_sel_t    sel_b_in,
    output fwd_sel_t    sel_shift_in,
    output logic        sel_shift,     // 1 means shift amount from rs
    output logic        en_a,
    output logic        en_b,
    output logic        en_s
);
    logic [1:0] form;
    logic       e_normal;
    logic       e_mem;
    logic       fwd_ok;
    logic       uses_a;
    logic       uses_b;
    logic       uses_s;

    execute_pipeline_unit u_pipeline (
        .clk          (clk),
        .arst_n       (arst_n),
        .instr_in     (instr_in),
        .squash_in    (squash_in),
        .sel_stall    (sel_stall),
        .cond         (),
        .opcode       (opcode),
        .rn           (rn),
        .rs           (rs),
        .rm           (rm),
        .rd           (rd),
        .imm5         (imm5),
        .instr_output ()
    );

    assign form     = opcode[5:4];
    assign e_normal = is_normal(opcode);  // never-executed words are already a nop here
    assign e_mem    = is_mem(opcode);

    // X result is only forwardable when it is a register write
    assign fwd_ok = opcode != opcode_nop && opcode_x != opcode_nop && is_normal(opcode_x);

    // sources the E instruction really reads
    assign uses_a = (e_normal && opcode[alu_a_bit]) || e_mem;
    assign uses_b = (e_normal && (form == form_r || form == form_rs))
                    || (e_mem && opcode[mem_reg_bit]);
    assign uses_s = e_normal && form == form_rs;

    always_comb begin
        sel_a_in     = sel_reg;
        sel_b_in     = sel_reg;
        sel_shift_in = sel_reg;
        if (fwd_ok && uses_a && rn == rd_x) begin
            sel_a_in = sel_alu;
        end
        if (fwd_ok && uses_b && rm == rd_x) begin
            sel_b_in = sel_alu;
        end
        if (fwd_ok && uses_s && rs == rd_x) begin
            sel_shift_in = sel_alu;
        end
    end

    // operand enables and shift source by opcode class
    always_comb begin
        sel_shift = 1'b0;
        en_a      = 1'b0;
        en_b      = 1'b0;
        en_s      = 1'b0;
        if (e_normal) begin
            sel_shift = form == form_rs;
            en_a      = opcode[alu_a_bit];   // mov/mvn skip A
            en_b      = 1'b1;                // rm or imm5
            en_s      = form == form_rs;
        end else if (e_mem) begin
            en_a = 1'b1;  // base from rn
            en_b = 1'b1;  // offset, rm or imm5
        end
    end

endmodule

// ==== hw/register_file.sv ====
module register_file (
    input  logic        clk,
    input  logic        arst_n,
    input  logic [3:0]  rd_addr_a,
    input  logic [3:0]  rd_addr_b,
    input  logic [3:0]  rd_addr_s,
    output logic [31:0] rd_data_a,
    output logic [31:0] rd_data_b,
    output logic [31:0] rd_data_s,
    input  logic        wr_en,
    input  logic [3:0]  wr_addr,
    input  logic [31:0] wr_data
);
    logic [31:0] regs [16];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // write-through, covers the instruction two stages ahead
    assign rd_data_a = (wr_en && wr_addr == rd_addr_a) ? wr_data : regs[rd_addr_a];
    assign rd_data_b = (wr_en && wr_addr == rd_addr_b) ? wr_data : regs[rd_addr_b];
    assign rd_data_s = (wr_en && wr_addr == rd_addr_s) ? wr_data : regs[rd_addr_s];

endmodule

// ==== hw/alu_datapath.sv ====
module alu_datapath
    import execute_pkg::*;
#(
    parameter int credit_width = 4
) (
    input  logic         clk,
    input  logic         arst_n,
    input  logic [31:0]  reg_a,
    input  logic [31:0]  reg_b,
    input  logic [31:0]  reg_s,
    input  logic [6:0]   opcode,
    input  logic [3:0]   rd,
    input  logic [4:0]   imm5,
    input  fwd_sel_t     sel_a_in,
    input  fwd_sel_t     sel_b_in,
    input  fwd_sel_t     sel_shift_in,
    input  logic         sel_shift,
    input  logic         en_a,
    input  logic         en_b,
    input  logic         en_s,
    output logic [6:0]   opcode_x,
    output logic [3:0]   rd_x,
    output logic         wr_en,
    output logic [3:0]   wr_addr,
    output logic [31:0]  wr_data,
    input  logic         result_credit,
    output logic         result_valid,
    output logic [31:0]  result_data,
    output logic [3:0]   result_rd,
    output result_kind_t result_kind,
    output logic         stall
);
    logic [31:0]             a_q;
    logic [31:0]             b_q;
    logic [31:0]             s_q;
    logic [4:0]              shamt_imm_x;
    logic                    sel_shift_x;
    logic [31:0]             a_in;
    logic [31:0]             b_in;
    logic [31:0]             s_in;
    logic                    b_imm;
    logic [4:0]              shamt;
    logic [31:0]             b_shifted;
    logic [31:0]             alu_out;
    logic                    x_mem;
    logic                    w_valid;
    logic [credit_width-1:0] credit_cnt;

    // imm forms put imm5 in B and do not shift
    assign b_imm = (is_normal(opcode) && opcode[5:4] == form_imm)
                   || (is_mem(opcode) && !opcode[mem_reg_bit]);

    assign a_in = (sel_a_in == sel_alu) ? alu_out : reg_a;
    assign b_in = b_imm ? {27'b0, imm5} : ((sel_b_in == sel_alu) ? alu_out : reg_b);
    assign s_in = (sel_shift_in == sel_alu) ? alu_out : reg_s;

    always_ff @(posedge clk) begin
        if (!stall && en_a) a_q <= a_in;
        if (!stall && en_b) b_q <= b_in;
        if (!stall && en_s) s_q <= s_in;
        if (!stall) begin
            rd_x        <= rd;
            shamt_imm_x <= b_imm ? 5'd0 : imm5;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            opcode_x    <= opcode_nop;
            sel_shift_x <= 1'b0;
        end else if (!stall) begin
            opcode_x    <= opcode;
            sel_shift_x <= sel_shift;
        end
    end

    assign shamt     = sel_shift_x ? s_q[4:0] : shamt_imm_x;
    assign b_shifted = b_q << shamt;
    assign x_mem     = is_mem(opcode_x);

    always_comb begin
        case (alu_op_t'(opcode_x[3:0]))
            alu_mov: alu_out = b_shifted;
            alu_mvn: alu_out = ~b_shifted;
            alu_add: alu_out = a_q + b_shifted;
            alu_sub: alu_out = a_q - b_shifted;
            alu_and: alu_out = a_q & b_shifted;
            alu_orr: alu_out = a_q | b_shifted;
            alu_eor: alu_out = a_q ^ b_shifted;
            default: alu_out = '0;
        endcase
        if (x_mem) alu_out = a_q + b_shifted;  // address, rn plus offset
    end

    // W stage
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            w_valid     <= 1'b0;
            result_kind <= kind_write;
        end else if (!stall) begin
            w_valid     <= is_normal(opcode_x) || x_mem;
            result_kind <= x_mem ? kind_addr : kind_write;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            result_data <= alu_out;
            result_rd   <= rd_x;
        end
    end

    assign wr_en   = w_valid && result_kind == kind_write;
    assign wr_addr = result_rd;
    assign wr_data = result_data;

    // output credits, one used per shown result
    assign result_valid = w_valid && credit_cnt != '0;
    assign stall        = w_valid && credit_cnt == '0;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            credit_cnt <= '0;
        end else if (result_credit && !result_valid) begin
            credit_cnt <= credit_cnt + 1'b1;
        end else if (!result_credit && result_valid) begin
            credit_cnt <= credit_cnt - 1'b1;
        end
    end

endmodule

// ==== hw/execute_top.sv ====
module execute_top
    import execute_pkg::*;
#(
    parameter int queue_depth  = 4,
    parameter int credit_width = 4
) (
    input  logic         clk,
    input  logic         arst_n,
    input  logic         instr_valid,
    input  logic [31:0]  instr,
    input  logic         squash,
    output logic         instr_credit,
    input  logic         result_credit,
    output logic         result_valid,
    output logic [31:0]  result_data,
    output logic [3:0]   result_rd,
    output result_kind_t result_kind
);
    logic        q_empty;
    logic [31:0] q_instr;
    logic        q_squash;
    logic        e_squash;
    logic        stall;
    logic [6:0]  opcode_e;
    logic [3:0]  rn_e;
    logic [3:0]  rs_e;
    logic [3:0]  rm_e;
    logic [3:0]  rd_e;
    logic [4:0]  imm5_e;
    logic [6:0]  opcode_x;
    logic [3:0]  rd_x;
    fwd_sel_t    sel_a_in;
    fwd_sel_t    sel_b_in;
    fwd_sel_t    sel_shift_in;
    logic        sel_shift;
    logic        en_a;
    logic        en_b;
    logic        en_s;
    logic [31:0] rd_data_a;
    logic [31:0] rd_data_b;
    logic [31:0] rd_data_s;
    logic        wr_en;
    logic [3:0]  wr_addr;
    logic [31:0] wr_data;

    assign e_squash = q_squash || q_empty;  // empty queue feeds a nop

    instr_credit_queue #(
        .queue_depth (queue_depth)
    ) u_queue (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_valid   (instr_valid),
        .in_instr   (instr),
        .in_squash  (squash),
        .pop        (!stall),
        .out_empty  (q_empty),
        .out_instr  (q_instr),
        .out_squash (q_squash),
        .credit     (instr_credit)
    );

    execute_unit u_execute (
        .clk          (clk),
        .arst_n       (arst_n),
        .instr_in     (q_instr),
        .squash_in    (e_squash),
        .sel_stall    (stall),
        .opcode       (opcode_e),
        .rn           (rn_e),
        .rs           (rs_e),
        .rm           (rm_e),
        .rd           (rd_e),
        .imm5         (imm5_e),
        .opcode_x     (opcode_x),
        .rd_x         (rd_x),
        .sel_a_in     (sel_a_in),
        .sel_b_in     (sel_b_in),
        .sel_shift_in (sel_shift_in),
        .sel_shift    (sel_shift),
        .en_a         (en_a),
        .en_b         (en_b),
        .en_s         (en_s)
    );

    register_file u_regfile (
        .clk       (clk),
        .arst_n    (arst_n),
        .rd_addr_a (rn_e),
        .rd_addr_b (rm_e),
        .rd_addr_s (rs_e),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b),
        .rd_data_s (rd_data_s),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data)
    );

    alu_datapath #(
        .credit_width (credit_width)
    ) u_datapath (
        .clk           (clk),
        .arst_n        (arst_n),
        .reg_a         (rd_data_a),
        .reg_b         (rd_data_b),
        .reg_s         (rd_data_s),
        .opcode        (opcode_e),
        .rd            (rd_e),
        .imm5          (imm5_e),
        .sel_a_in      (sel_a_in),
        .sel_b_in      (sel_b_in),
        .sel_shift_in  (sel_shift_in),
        .sel_shift     (sel_shift),
        .en_a          (en_a),
        .en_b          (en_b),
        .en_s          (en_s),
        .opcode_x      (opcode_x),
        .rd_x          (rd_x),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .result_credit (result_credit),
        .result_valid  (result_valid),
        .result_data   (result_data),
        .result_rd     (result_rd),
        .result_kind   (result_kind),
        .stall         (stall)
    );

endmodule

// ==== verification/execute_tb.sv ====
module execute_tb
    import execute_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int queue_depth    = 4;
    localparam int credit_width   = 4;
    localparam int max_owed       = 8;  // outstanding result credits, fits the 4-bit counter
    localparam int n_wide         = 80;
    localparam int n_narrow       = 240;
    localparam int n_starve       = 80;
    localparam int n_total        = n_wide + n_narrow + n_starve;
    localparam int timeout_cycles = 20 * n_total + 200;

    localparam logic [3:0] alu_codes [7] = '{alu_mov, alu_mvn, alu_add, alu_sub,
                                             alu_and, alu_orr, alu_eor};

    logic         clk;
    logic         arst_n;
    logic         instr_valid;
    logic [31:0]  instr;
    logic         squash;
    logic         instr_credit;
    logic         result_credit;
    logic         result_valid;
    logic [31:0]  result_data;
    logic [3:0]   result_rd;
    result_kind_t result_kind;

    logic [31:0]  model_regs [16];  // isa-level register state
    logic [31:0]  exp_data_q [$];
    logic [3:0]   exp_rd_q [$];
    result_kind_t exp_kind_q [$];
    int           issuer_credits;
    int           sent_count;
    int           credit_pulses;
    int           credits_given;
    int           results_seen;
    int           cycle_count;
    int           mismatch_count;
    int           fail_count;

    execute_top #(
        .queue_depth  (queue_depth),
        .credit_width (credit_width)
    ) u_dut (
        .clk           (clk),
        .arst_n        (arst_n),
        .instr_valid   (instr_valid),
        .instr         (instr),
        .squash        (squash),
        .instr_credit  (instr_credit),
        .result_credit (result_credit),
        .result_valid  (result_valid),
        .result_data   (result_data),
        .result_rd     (result_rd),
        .result_kind   (result_kind)
    );

    always #2 clk = ~clk;

    task automatic check_data(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("mismatch at %0d ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_rd(input string name, input logic [3:0] got, input logic [3:0] exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("mismatch at %0d ns: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_kind(input string name, input result_kind_t got,
                              input result_kind_t exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("mismatch at %0d ns: %s got %s expected %s",
                     $time, name, got.name(), exp.name());
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("mismatch at %0d ns: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic report_error(input string msg);
        fail_count++;
        $display("error at %0d ns: %s", $time, msg);
    endtask

    function automatic void push_expected(input logic [31:0] data, input logic [3:0] rd,
                                          input result_kind_t kind);
        exp_data_q.push_back(data);
        exp_rd_q.push_back(rd);
        exp_kind_q.push_back(kind);
    endfunction

    // in-order reference, nothing for squashed, never or nop
    function automatic void model_step(input logic [31:0] word, input logic sq);
        logic [6:0]  op;
        logic [3:0]  rd;
        logic [4:0]  imm;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        op  = word[27:21];
        rd  = word[20:17];
        imm = word[4:0];
        a   = model_regs[word[16:13]];
        if (!sq && word[31:28] != cond_never && op != opcode_nop) begin
            if (op[6:5] == 2'b11) begin
                b = op[3] ? (model_regs[word[8:5]] << imm) : {27'b0, imm};
                push_expected(a + b, rd, kind_addr);  // address only, no write
            end else begin
                case (op[5:4])
                    2'b00:   b = {27'b0, imm};
                    2'b01:   b = model_regs[word[8:5]] << imm;
                    default: b = model_regs[word[8:5]] << model_regs[word[12:9]][4:0];
                endcase
                case (op[3:0])
                    4'b0000: res = b;
                    4'b0001: res = ~b;
                    4'b1000: res = a + b;
                    4'b1001: res = a - b;
                    4'b1010: res = a & b;
                    4'b1011: res = a | b;
                    default: res = a ^ b;
                endcase
                model_regs[rd] = res;
                push_expected(res, rd, kind_write);
            end
        end
    endfunction

    function automatic logic [3:0] pick_reg(input bit narrow);
        return narrow ? 4'($urandom_range(3)) : 4'($urandom_range(15));
    endfunction

    function automatic logic [31:0] make_instr(input bit narrow);
        logic [3:0] cond;
        logic [6:0] op;
        logic [1:0] form;
        int         pick;
        pick = int'($urandom_range(99));
        cond = (pick < 5) ? cond_never : 4'($urandom_range(14));
        pick = int'($urandom_range(99));
        if (pick < 6) begin
            op = opcode_nop;
        end else if (pick < 24) begin
            op = {2'b11, 1'($urandom_range(1)), 1'($urandom_range(1)), 3'b000};  // ldr/str
        end else begin
            pick = int'($urandom_range(2));
            form = (pick == 0) ? 2'b00 : ((pick == 1) ? 2'b01 : 2'b11);
            op   = {1'b0, form, alu_codes[3'($urandom_range(6))]};
        end
        return {cond, op, pick_reg(narrow), pick_reg(narrow), pick_reg(narrow),
                pick_reg(narrow), 5'($urandom_range(31))};
    endfunction

    task automatic give_credit(input int pct);
        if (credits_given - results_seen < max_owed && int'($urandom_range(99)) < pct) begin
            result_credit <= 1'b1;
            credits_given++;
        end else begin
            result_credit <= 1'b0;
        end
    endtask

    task automatic send_instr(input bit narrow);
        logic [31:0] word;
        logic        sq;
        word = make_instr(narrow);
        sq   = $urandom_range(99) < 8;
        model_step(word, sq);
        instr_valid <= 1'b1;
        instr       <= word;
        squash      <= sq;
        issuer_credits--;
        sent_count++;
    endtask

    task automatic issue_phase(input int count, input bit narrow, input int send_pct,
                               input int credit_pct);
        int sent_here;
        sent_here = 0;
        while (sent_here < count) begin
            @(posedge clk);
            give_credit(credit_pct);
            if (issuer_credits > 0 && int'($urandom_range(99)) < send_pct) begin
                send_instr(narrow);
                sent_here++;
            end else begin
                instr_valid <= 1'b0;
            end
        end
    endtask

    // outputs sampled mid-cycle
    always @(negedge clk) begin
        if (arst_n) begin
            if (instr_credit) begin
                issuer_credits++;
                credit_pulses++;
                if (issuer_credits > queue_depth) begin
                    report_error("instr_credit returned more credits than the queue holds");
                end
            end
            if (result_valid) begin
                results_seen++;
                if (results_seen > credits_given) begin
                    report_error("more results shown than result credits given");
                end
                if (exp_data_q.size() == 0) begin
                    report_error("result shown while none was expected");
                end else begin
                    check_data("result_data", result_data, exp_data_q.pop_front());
                    check_rd("result_rd", result_rd, exp_rd_q.pop_front());
                    check_kind("result_kind", result_kind, exp_kind_q.pop_front());
                end
            end
        end
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < timeout_cycles) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout after %0d cycles with %0d results still missing",
                 cycle_count, exp_data_q.size());
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, fail_count + 1);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        void'($urandom(50375));
        clk            = 1'b0;
        issuer_credits = queue_depth;
        sent_count     = 0;
        credit_pulses  = 0;
        credits_given  = 0;
        results_seen   = 0;
        mismatch_count = 0;
        fail_count     = 0;
        for (int i = 0; i < 16; i++) begin
            model_regs[i] = '0;
        end
        arst_n        <= 1'b0;
        instr_valid   <= 1'b0;
        instr         <= '0;
        squash        <= 1'b0;
        result_credit <= 1'b0;
        repeat (16) @(posedge clk);
        arst_n <= 1'b1;

        // idle, nothing sent and no result credits
        repeat (24) begin
            @(negedge clk);
            check_flag("result_valid", result_valid, 1'b0);
            check_flag("instr_credit", instr_credit, 1'b0);
        end

        issue_phase(n_wide, 1'b0, 70, 50);
        issue_phase(n_narrow, 1'b1, 95, 60);  // dense hazards on r0..r3
        issue_phase(n_starve, 1'b1, 35, 12);  // both sides starved

        while (exp_data_q.size() != 0 || credit_pulses != sent_count) begin
            @(posedge clk);
            instr_valid <= 1'b0;
            give_credit(50);
        end
        repeat (20) begin  // no stray results after drain
            @(posedge clk);
            instr_valid <= 1'b0;
            give_credit(50);
        end
        @(negedge clk);
        if (credit_pulses != sent_count) begin
            report_error("instr_credit pulse count differs from instructions sent");
        end
        if (issuer_credits != queue_depth) begin
            report_error("issuer did not get all its credits back");
        end

        $display("errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
        if (mismatch_count == 0 && fail_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== execute_subsystem.f ====
hw/execute_pkg.sv
hw/instr_credit_queue.sv
hw/execute_pipeline_unit.sv
hw/execute_unit.sv
hw/register_file.sv
hw/alu_datapath.sv
hw/execute_top.sv
verification/execute_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the execute subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
    --timescale 1ns/100ps \
    --top-module execute_tb \
    -f execute_subsystem.f \
    -o execute_tb_sim

./obj_dir/execute_tb_sim > sim.log
cat sim.log

if grep -q "Simulation failed" sim.log; then
    echo "run failed, see sim.log"
    exit 1
fi
echo "run finished, see sim.log"
